// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_frontend \
		-f sim.f -Mdir obj_dir -o tb_frontend
	./obj_dir/tb_frontend | tee /dev/stderr | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir

// ==== sim.f ====
verilog/fe_pkg.sv
verilog/fetch_unit.sv
verilog/inst_buffer.sv
verilog/decode_stage.sv
verilog/regfile.sv
verilog/operand_stage.sv
verilog/frontend.sv
test/line_memory_model.sv
test/tb_frontend.sv

// ==== test/line_memory_model.sv ====
`default_nettype none

module line_memory_model import fe_pkg::*; #(
    parameter pc_t BASE = 48'h8000_0000
) (
    input  wire         clock,
    input  inst_t       image [128],

    input  wire         line_req_valid,
    input  line_index_t line_req_index,
    output logic        line_req_ready,

    output logic        line_resp_valid,
    output line_t       line_resp_data
);
    timeunit 1ns;
    timeprecision 1ps;

    int          seed;
    logic        accepted;
    line_index_t accepted_index;
    logic        pending;
    int          delay;
    line_index_t pending_index;

    // image wraps every 128 words
    function automatic line_t build_line(line_index_t idx);
        line_t      l;
        logic [6:0] wi;
        wi = 7'((pc_t'({idx, 6'b0}) - BASE) >> 2);
        for (int k = 0; k < 16; k++) begin
            l[32*k +: 32] = image[wi + 7'(k)];
        end
        return l;
    endfunction

    always @(posedge clock) begin
        accepted       <= line_req_valid && line_req_ready;
        accepted_index <= line_req_index;
    end

    initial begin
        seed            = 92704;
        line_req_ready  = 1'b0;
        line_resp_valid = 1'b0;
        line_resp_data  = '0;
        pending         = 1'b0;
        delay           = 0;
        pending_index   = '0;
        forever begin
            @(negedge clock);
            line_resp_valid = 1'b0;
            if (pending) begin
                if (delay == 1) begin
                    line_resp_valid = 1'b1;
                    line_resp_data  = build_line(pending_index);
                    pending         = 1'b0;
                end else begin
                    delay = delay - 1;
                end
            end
            if (accepted) begin
                pending       = 1'b1;
                pending_index = accepted_index;
                delay         = 1 + ($random(seed) & 3); // 1 to 4 cycles
            end
            line_req_ready = ($random(seed) & 3) != 0;
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_frontend.sv ====
`default_nettype none

module tb_frontend import fe_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam pc_t BOOT_ADDR  = 48'h8000_0000;
    localparam int  N_EXPECTED = 36;
    localparam int  MAX_CYCLES = N_EXPECTED * 50 + 200; // slow memory and random stalls

    logic        clock;
    logic        arst_n;
    logic        line_req_valid;
    line_index_t line_req_index;
    logic        line_req_ready;
    logic        line_resp_valid;
    line_t       line_resp_data;
    logic        redirect_valid;
    pc_t         redirect_target;
    bypass_t     wb;
    bypass_t     ex_byp;
    bypass_t     mem_byp;
    logic        issue_valid;
    logic        issue_ready;
    decoded_t    issue_inst;
    xreg_t       src1;
    xreg_t       src2;

    inst_t    image [128];
    pc_t      exp_q [$];
    decoded_t exp_dec;
    logic     exp_empty;
    xreg_t    exp_src1;
    xreg_t    exp_src2;
    xreg_t    rf_model [32];
    logic     fired;
    logic     req_taken;
    logic     fire;
    int       seed;
    int       quiet;
    int       issued;
    int       cycles = 0;
    int       fetch_errs = 0;
    int       field_errs = 0;
    int       src_errs = 0;
    int       stable_errs = 0;
    int       extra_errs = 0;
    int       main_errs = 0;
    int       fetch_snap;
    int       src_snap;

    frontend #(
        .BOOT_ADDR (BOOT_ADDR),
        .IBUF_DEPTH(8)
    ) dut (
        .clock          (clock),
        .arst_n         (arst_n),
        .line_req_valid (line_req_valid),
        .line_req_index (line_req_index),
        .line_req_ready (line_req_ready),
        .line_resp_valid(line_resp_valid),
        .line_resp_data (line_resp_data),
        .redirect_valid (redirect_valid),
        .redirect_target(redirect_target),
        .wb             (wb),
        .ex_byp         (ex_byp),
        .mem_byp        (mem_byp),
        .issue_valid    (issue_valid),
        .issue_ready    (issue_ready),
        .issue_inst     (issue_inst),
        .src1           (src1),
        .src2           (src2)
    );

    line_memory_model #(
        .BASE(BOOT_ADDR)
    ) mem (
        .clock          (clock),
        .image          (image),
        .line_req_valid (line_req_valid),
        .line_req_index (line_req_index),
        .line_req_ready (line_req_ready),
        .line_resp_valid(line_resp_valid),
        .line_resp_data (line_resp_data)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // addi with an immediate folded from all address bits
    function automatic inst_t fill_word(pc_t a);
        logic [11:0] h;
        h = a[11:0] ^ a[23:12] ^ a[35:24] ^ a[47:36];
        return {h, 5'd0, 3'b000, a[6:2], 7'b0010011};
    endfunction

    function automatic inst_t image_at(pc_t pc);
        return image[7'((pc - BOOT_ADDR) >> 2)];
    endfunction

    function automatic alu_op_t alu_of(logic [2:0] f3, logic alt);
        case (f3)
            3'd0:    return alt ? 4'd1 : 4'd0;
            3'd1:    return 4'd2;
            3'd2:    return 4'd3;
            3'd3:    return 4'd4;
            3'd4:    return 4'd5;
            3'd5:    return alt ? 4'd7 : 4'd6;
            3'd6:    return 4'd8;
            default: return 4'd9;
        endcase
    endfunction

    // reference decode straight from the RV64I encodings
    function automatic decoded_t model_decode(pc_t pc, inst_t w);
        decoded_t   m;
        logic [2:0] f3;
        logic [6:0] f7;
        m      = '0;
        f3     = w[14:12];
        f7     = w[31:25];
        m.pc   = pc;
        m.inst = w;
        m.rd   = w[11:7];
        m.rs1  = w[19:15];
        m.rs2  = w[24:20];
        case (w[6:0])
            7'b0110011: begin
                m.src1_is_reg = 1'b1;
                m.src2_is_reg = 1'b1;
                m.alu_op      = alu_of(f3, w[30]);
                m.is_illegal  = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
            end
            7'b0010011: begin
                m.src1_is_reg = 1'b1;
                m.imm         = {{52{w[31]}}, w[31:20]};
                m.alu_op      = alu_of(f3, f3 == 3'd5 && w[30]);
                if (f3 == 3'd1) m.is_illegal = w[31:26] != 6'h00;
                if (f3 == 3'd5) m.is_illegal = w[31:26] != 6'h00 && w[31:26] != 6'h10;
            end
            7'b0000011: begin
                m.src1_is_reg = 1'b1;
                m.imm         = {{52{w[31]}}, w[31:20]};
                m.is_load     = 1'b1;
                m.ls_size     = f3[1:0];
                m.is_unsigned = f3[2]; // lbu, lhu, lwu
                m.is_illegal  = f3 == 3'd7;
            end
            7'b0100011: begin
                m.src1_is_reg = 1'b1;
                m.src2_is_reg = 1'b1;
                m.imm         = {{52{w[31]}}, w[31:25], w[11:7]};
                m.is_store    = 1'b1;
                m.ls_size     = f3[1:0];
                m.is_illegal  = f3[2];
            end
            7'b0110111, 7'b0010111: m.imm = {{32{w[31]}}, w[31:12], 12'h000};
            default: m.is_illegal = 1'b1;
        endcase
        m.need_to_wb = !m.is_store && !m.is_illegal && m.rd != 5'd0;
        return m;
    endfunction

    function automatic logic [91:0] field_key(decoded_t d);
        return {d.rd, d.rs1, d.rs2, d.imm, d.alu_op, d.is_load, d.is_store, d.ls_size,
                d.is_unsigned, d.src1_is_reg, d.src2_is_reg, d.need_to_wb, d.is_illegal};
    endfunction

    // expected operands, ex over mem over register file
    always_comb begin
        exp_src1 = (exp_dec.rs1 == 5'd0) ? '0 : rf_model[exp_dec.rs1];
        if (exp_dec.rs1 != 5'd0 && mem_byp.valid && mem_byp.rd == exp_dec.rs1)
            exp_src1 = mem_byp.result;
        if (exp_dec.rs1 != 5'd0 && ex_byp.valid && ex_byp.rd == exp_dec.rs1)
            exp_src1 = ex_byp.result;
        if (!exp_dec.src1_is_reg)
            exp_src1 = (exp_dec.inst[6:0] == 7'b0010111) ? 64'(exp_dec.pc) : '0;
        exp_src2 = (exp_dec.rs2 == 5'd0) ? '0 : rf_model[exp_dec.rs2];
        if (exp_dec.rs2 != 5'd0 && mem_byp.valid && mem_byp.rd == exp_dec.rs2)
            exp_src2 = mem_byp.result;
        if (exp_dec.rs2 != 5'd0 && ex_byp.valid && ex_byp.rd == exp_dec.rs2)
            exp_src2 = ex_byp.result;
        if (!exp_dec.src2_is_reg)
            exp_src2 = exp_dec.imm;
    end

    assign fire = issue_valid && issue_ready;

    always @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            fired     <= 1'b0;
            req_taken <= 1'b0;
            for (int i = 0; i < 32; i++) begin
                rf_model[i] <= '0;
            end
        end else begin
            fired     <= fire;
            req_taken <= line_req_valid && line_req_ready;
            if (wb.valid && wb.rd != 5'd0) rf_model[wb.rd] <= wb.result;
        end
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: only %0d of %0d instructions issued", issued, N_EXPECTED);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // decode register is invalidated at the redirect edge
    assert property (@(posedge clock) disable iff (!arst_n) redirect_valid |=> !issue_valid)
        else begin
            extra_errs++;
            $display("instruction at pc %h still valid after a redirect",
                     $sampled(issue_inst.pc));
        end

    assert property (@(posedge clock) disable iff (!arst_n) fire && !exp_empty |->
                     issue_inst.pc == exp_dec.pc && issue_inst.inst == exp_dec.inst)
        else begin
            fetch_errs++;
            $display("error: issue_inst.pc = %h inst = %h, expected %h %h",
                     $sampled(issue_inst.pc), $sampled(issue_inst.inst),
                     $sampled(exp_dec.pc), $sampled(exp_dec.inst));
        end

    assert property (@(posedge clock) disable iff (!arst_n) fire && !exp_empty |->
                     field_key(issue_inst) == field_key(exp_dec))
        else begin
            field_errs++;
            $display("error: issue_inst fields = %h, expected %h",
                     field_key($sampled(issue_inst)), field_key($sampled(exp_dec)));
        end

    assert property (@(posedge clock) disable iff (!arst_n) fire && !exp_empty |->
                     src1 == exp_src1 && src2 == exp_src2)
        else begin
            src_errs++;
            $display("error: src1 = %h src2 = %h, expected %h %h", $sampled(src1),
                     $sampled(src2), $sampled(exp_src1), $sampled(exp_src2));
        end

    // quiet marks cycles where bypass or write-back moved the operands
    assert property (@(posedge clock) disable iff (!arst_n)
                     issue_valid && !issue_ready && !redirect_valid |=>
                     issue_valid && (quiet != 0 || ($stable(issue_inst) &&
                     $stable(src1) && $stable(src2))))
        else begin
            stable_errs++;
            $display("issue output changed while stalled at pc %h", $sampled(issue_inst.pc));
        end

    task automatic refresh_expected();
        if (exp_q.size() == 0) begin
            exp_empty = 1'b1;
            exp_dec   = '0;
        end else begin
            exp_empty = 1'b0;
            exp_dec   = model_decode(exp_q[0], image_at(exp_q[0]));
        end
    endtask

    task automatic step();
        @(negedge clock);
        if (quiet != 0) quiet--;
        if (fired) begin
            issued++;
            if (exp_q.size() != 0) void'(exp_q.pop_front());
        end
        refresh_expected();
    endtask

    task automatic expect_run(pc_t start, int n);
        exp_q.delete();
        for (int i = 0; i < n; i++) begin
            exp_q.push_back(start + pc_t'(4 * i));
        end
        refresh_expected();
    endtask

    task automatic write_back(lreg_t rd, xreg_t value);
        wb    = '{valid: 1'b1, rd: rd, result: value};
        quiet = 2;
        step();
        wb.valid = 1'b0;
    endtask

    task automatic report_test(int n, string name, int errs);
        $display("test %0d %s: %s", n, name, errs == 0 ? "ok" : "failed");
    endtask

    initial begin
        seed            = 92704;
        arst_n          = 1'b0;
        redirect_valid  = 1'b0;
        redirect_target = '0;
        wb              = '0;
        ex_byp          = '0;
        mem_byp         = '0;
        issue_ready     = 1'b0;
        quiet           = 0;
        issued          = 0;
        exp_empty       = 1'b1;
        exp_dec         = '0;
        for (int i = 0; i < 128; i++) begin
            image[i] = fill_word(BOOT_ADDR + pc_t'(4 * i));
        end
        image[0]  = 32'h006281B3; // add  x3, x5, x6
        image[1]  = 32'h40628233; // sub  x4, x5, x6
        image[2]  = 32'hFFF28393; // addi x7, x5, -1
        image[3]  = 32'h01033403; // ld   x8, 16(x6)
        image[4]  = 32'h00533423; // sd   x5, 8(x6)
        image[5]  = 32'h800014B7; // lui
        image[6]  = 32'h00012517; // auipc
        image[7]  = 32'h4032D593; // srai x11, x5, 3
        image[8]  = 32'h0000006F; // jal, not decoded
        image[9]  = 32'h00628033; // add  x0, x5, x6
        image[10] = 32'hFFC2C603; // lbu  x12, -4(x5)
        image[11] = 32'h006046B3; // xor  x13, x0, x6
        for (int i = 50; i < 54; i++) begin
            image[i] = 32'h0010E733; // or x14, x1, x1
        end
        image[54] = 32'h006046B3;
        image[55] = 32'h0010E733;

        repeat (3) @(negedge clock);
        assert (!issue_valid && !line_req_valid)
            else begin
                main_errs++;
                $display("outputs were active during reset");
            end
        arst_n = 1'b1;

        // sequential fetch across the first line boundary
        expect_run(BOOT_ADDR, 20);
        write_back(5'd5, 64'h1234_5678_9ABC_DEF0);
        write_back(5'd6, 64'hFFFF_0000_8000_0010);
        write_back(5'd1, 64'h0000_0000_0000_1111);
        write_back(5'd0, 64'h0000_0000_0000_DEAD);
        while (issued < 20) begin
            step();
            issue_ready = issued < 20 && ($random(seed) & 1) != 0;
        end
        fetch_snap = fetch_errs + extra_errs;
        src_snap   = src_errs;
        report_test(1, "sequential fetch", fetch_snap);
        report_test(3, "write-back reads", src_snap);

        // park fetch elsewhere, then redirect while its request is in flight
        issue_ready     = 1'b0;
        redirect_valid  = 1'b1;
        redirect_target = BOOT_ADDR + 48'h80;
        exp_q.delete();
        refresh_expected();
        step();
        redirect_valid = 1'b0;
        do begin
            step();
        end while (!req_taken);
        redirect_valid  = 1'b1;
        redirect_target = BOOT_ADDR + 48'hC8;
        expect_run(BOOT_ADDR + 48'hC8, N_EXPECTED - 20);
        ex_byp  = '{valid: 1'b1, rd: 5'd1, result: 64'hAAAA_0000_0000_0001};
        mem_byp = '{valid: 1'b1, rd: 5'd1, result: 64'hBBBB_0000_0000_0002};
        quiet   = 2;
        step();
        redirect_valid = 1'b0;
        while (issued < N_EXPECTED) begin
            step();
            if (issued - 20 >= 4 && mem_byp.rd != 5'd0) begin
                ex_byp  = '{valid: 1'b1, rd: 5'd0, result: 64'hCCCC_0000_0000_0003};
                mem_byp = '{valid: 1'b1, rd: 5'd0, result: 64'hDDDD_0000_0000_0004};
                quiet   = 2;
            end else if (issued - 20 >= 2 && ex_byp.valid && ex_byp.rd != 5'd0) begin
                ex_byp.valid = 1'b0; // mem takes over
                quiet        = 2;
            end
            issue_ready = issued < N_EXPECTED && ($random(seed) & 1) != 0;
        end
        issue_ready = 1'b0;
        repeat (10) step();

        // the next instruction waits at the issue output, nothing dropped
        assert (issue_valid)
            else begin
                main_errs++;
                $display("no instruction held at the issue output after %0d issued", issued);
            end
        assert (issue_inst.pc == BOOT_ADDR + 48'hC8 + pc_t'(4 * (N_EXPECTED - 20)))
            else begin
                main_errs++;
                $display("error: issue_inst.pc = %h, expected %h", issue_inst.pc,
                         BOOT_ADDR + 48'hC8 + pc_t'(4 * (N_EXPECTED - 20)));
            end
        report_test(2, "decode fields", field_errs);
        report_test(4, "forwarding", src_errs - src_snap);
        report_test(5, "redirect", fetch_errs + extra_errs - fetch_snap);
        report_test(6, "back-pressure", stable_errs + main_errs);
        $display("%0d instructions issued, %0d checks failed", issued,
                 fetch_errs + field_errs + src_errs + stable_errs + extra_errs + main_errs);
        if (fetch_errs + field_errs + src_errs + stable_errs + extra_errs + main_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/decode_stage.sv ====
`default_nettype none

module decode_stage import fe_pkg::*; (
    input  wire         clock,
    input  wire         arst_n,
    input  wire         flush,

    input  wire         head_valid,
    input  ibuf_entry_t head_entry,
    output logic        head_ready,

    output logic        dec_valid,
    output decoded_t    dec_inst,
    input  wire         dec_ready
);

    inst_t      inst;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xreg_t      imm_i;
    xreg_t      imm_s;
    xreg_t      imm_u;
    alu_op_t    alu_op;
    decoded_t   d;

    assign inst   = head_entry.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{52{inst[31]}}, inst[31:20]};
    assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};

    // funct3 to alu op, bit 30 picks sub/sra
    always_comb begin
        case (funct3)
            3'b000:  alu_op = (opcode == OPC_OP && inst[30]) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op = ALU_SLL;
            3'b010:  alu_op = ALU_SLT;
            3'b011:  alu_op = ALU_SLTU;
            3'b100:  alu_op = ALU_XOR;
            3'b101:  alu_op = inst[30] ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
    end

    always_comb begin
        d      = '0;
        d.pc   = head_entry.pc;
        d.inst = inst;
        d.rs1  = inst[19:15];
        d.rs2  = inst[24:20];
        d.rd   = inst[11:7];
        case (opcode)
            OPC_OP: begin
                d.src1_is_reg = 1'b1;
                d.src2_is_reg = 1'b1;
                d.alu_op      = alu_op;
                // only add/sub and srl/sra have an alternate funct7
                d.is_illegal  = !(funct7 == 7'b0000000 ||
                                 (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            OPC_OP_IMM: begin
                d.src1_is_reg = 1'b1;
                d.imm         = imm_i;
                d.alu_op      = alu_op;
                if (funct3 == 3'b001) d.is_illegal = (inst[31:26] != 6'b000000);
                if (funct3 == 3'b101) d.is_illegal = (inst[31:26] != 6'b000000) &&
                                                     (inst[31:26] != 6'b010000);
            end
            OPC_LOAD: begin
                d.src1_is_reg = 1'b1;
                d.imm         = imm_i;
                d.alu_op      = ALU_ADD;
                d.is_load     = 1'b1;
                d.ls_size     = funct3[1:0];
                d.is_unsigned = funct3[2];
                d.is_illegal  = (funct3 == 3'b111); // no ldu
            end
            OPC_STORE: begin
                d.src1_is_reg = 1'b1;
                d.src2_is_reg = 1'b1;
                d.imm         = imm_s;
                d.alu_op      = ALU_ADD;
                d.is_store    = 1'b1;
                d.ls_size     = funct3[1:0];
                d.is_illegal  = funct3[2];
            end
            OPC_LUI, OPC_AUIPC: begin
                d.imm    = imm_u;
                d.alu_op = ALU_ADD; // src1 chosen later, zero or pc
            end
            default: d.is_illegal = 1'b1;
        endcase
        d.need_to_wb = !d.is_store && !d.is_illegal && (d.rd != '0);
    end

    // accept when empty or when the output moves on
    assign head_ready = !dec_valid || dec_ready;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
        end else if (flush) begin
            dec_valid <= 1'b0;
        end else if (head_ready) begin
            dec_valid <= head_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (head_ready && head_valid) dec_inst <= d;
    end

endmodule

`default_nettype wire

// ==== verilog/fe_pkg.sv ====
`default_nettype none

package fe_pkg;

    parameter int XLEN = 64;

    typedef logic [47:0]     pc_t;
    typedef logic [31:0]     inst_t;
    typedef logic [511:0]    line_t;       // sixteen instructions
    typedef logic [41:0]     line_index_t; // pc >> 6
    typedef logic [XLEN-1:0] xreg_t;
    typedef logic [4:0]      lreg_t;
    typedef logic [3:0]      alu_op_t;
    typedef logic [1:0]      ls_size_t;    // b, h, w, d

    // alu ops, same order as funct3 with sub and sra slotted in
    parameter alu_op_t ALU_ADD  = 4'd0;
    parameter alu_op_t ALU_SUB  = 4'd1;
    parameter alu_op_t ALU_SLL  = 4'd2;
    parameter alu_op_t ALU_SLT  = 4'd3;
    parameter alu_op_t ALU_SLTU = 4'd4;
    parameter alu_op_t ALU_XOR  = 4'd5;
    parameter alu_op_t ALU_SRL  = 4'd6;
    parameter alu_op_t ALU_SRA  = 4'd7;
    parameter alu_op_t ALU_OR   = 4'd8;
    parameter alu_op_t ALU_AND  = 4'd9;

    // major opcodes handled by decode
    parameter logic [6:0] OPC_OP     = 7'b0110011;
    parameter logic [6:0] OPC_OP_IMM = 7'b0010011;
    parameter logic [6:0] OPC_LOAD   = 7'b0000011;
    parameter logic [6:0] OPC_STORE  = 7'b0100011;
    parameter logic [6:0] OPC_LUI    = 7'b0110111;
    parameter logic [6:0] OPC_AUIPC  = 7'b0010111;

    typedef struct packed {
        pc_t   pc;
        inst_t inst;
    } ibuf_entry_t;

    typedef struct packed {
        pc_t      pc;
        inst_t    inst;
        lreg_t    rs1;
        lreg_t    rs2;
        lreg_t    rd;
        xreg_t    imm;          // sign-extended
        logic     src1_is_reg;
        logic     src2_is_reg;
        logic     need_to_wb;
        alu_op_t  alu_op;
        logic     is_load;
        logic     is_store;
        ls_size_t ls_size;
        logic     is_unsigned;
        logic     is_illegal;
    } decoded_t;

    typedef struct packed {
        logic  valid;
        lreg_t rd;
        xreg_t result;
    } bypass_t;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT,
        UNPACK
    } fetch_state_t;

endpackage

`default_nettype wire

// ==== verilog/fetch_unit.sv ====
`default_nettype none

module fetch_unit import fe_pkg::*; #(
    parameter pc_t BOOT_ADDR = 48'h8000_0000
) (
    input  wire         clock,
    input  wire         arst_n,

    input  wire         redirect_valid,
    input  pc_t         redirect_target,

    output logic        line_req_valid,
    output line_index_t line_req_index,
    input  wire         line_req_ready,

    input  wire         line_resp_valid,
    input  line_t       line_resp_data,

    output logic        push_valid,
    output ibuf_entry_t push_entry,
    input  wire         push_ready
);

    fetch_state_t state;
    pc_t          pc;
    line_t        line_q;
    logic         drop; // outstanding response is stale

    assign line_req_valid  = (state == REQ);
    assign line_req_index  = pc[47:6];
    assign push_valid      = (state == UNPACK);
    assign push_entry.pc   = pc;
    assign push_entry.inst = line_q[{pc[5:2], 5'b0} +: 32];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            pc    <= BOOT_ADDR;
            drop  <= 1'b0;
        end else if (redirect_valid) begin
            pc <= redirect_target;
            case (state)
                REQ: begin
                    if (line_req_ready) begin // old request got out anyway
                        state <= WAIT;
                        drop  <= 1'b1;
                    end
                end
                WAIT: begin
                    if (line_resp_valid) begin
                        state <= REQ;
                        drop  <= 1'b0;
                    end else begin
                        drop <= 1'b1;
                    end
                end
                default: state <= REQ;
            endcase
        end else begin
            case (state)
                IDLE: state <= REQ;
                REQ: begin
                    if (line_req_ready) state <= WAIT;
                end
                WAIT: begin
                    if (line_resp_valid) begin
                        drop  <= 1'b0;
                        state <= drop ? REQ : UNPACK;
                    end
                end
                UNPACK: begin
                    if (push_ready) begin
                        pc <= pc + pc_t'(4);
                        if (&pc[5:2]) state <= REQ; // last slot of the line
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == WAIT && line_resp_valid && !drop) line_q <= line_resp_data;
    end

endmodule

`default_nettype wire

// ==== verilog/frontend.sv ====
`default_nettype none

module frontend import fe_pkg::*; #(
    parameter pc_t BOOT_ADDR  = 48'h8000_0000,
    parameter int  IBUF_DEPTH = 8
) (
    input  wire         clock,
    input  wire         arst_n,

    output logic        line_req_valid,
    output line_index_t line_req_index,
    input  wire         line_req_ready,
    input  wire         line_resp_valid,
    input  line_t       line_resp_data,

    input  wire         redirect_valid,
    input  pc_t         redirect_target,

    input  bypass_t     wb,
    input  bypass_t     ex_byp,
    input  bypass_t     mem_byp,

    output logic        issue_valid,
    input  wire         issue_ready,
    output decoded_t    issue_inst,
    output xreg_t       src1,
    output xreg_t       src2
);

    logic        push_valid;
    logic        push_ready;
    ibuf_entry_t push_entry;
    logic        head_valid;
    logic        head_ready;
    ibuf_entry_t head_entry;
    logic        dec_valid;
    logic        dec_ready;
    decoded_t    dec_inst;
    lreg_t       rs1;
    lreg_t       rs2;
    xreg_t       rs1_data;
    xreg_t       rs2_data;

    fetch_unit #(
        .BOOT_ADDR(BOOT_ADDR)
    ) u_fetch_unit (
        .clock          (clock),
        .arst_n         (arst_n),
        .redirect_valid (redirect_valid),
        .redirect_target(redirect_target),
        .line_req_valid (line_req_valid),
        .line_req_index (line_req_index),
        .line_req_ready (line_req_ready),
        .line_resp_valid(line_resp_valid),
        .line_resp_data (line_resp_data),
        .push_valid     (push_valid),
        .push_entry     (push_entry),
        .push_ready     (push_ready)
    );

    inst_buffer #(
        .DEPTH(IBUF_DEPTH)
    ) u_inst_buffer (
        .clock     (clock),
        .arst_n    (arst_n),
        .flush     (redirect_valid),
        .push_valid(push_valid),
        .push_entry(push_entry),
        .push_ready(push_ready),
        .head_valid(head_valid),
        .head_entry(head_entry),
        .head_ready(head_ready)
    );

    decode_stage u_decode_stage (
        .clock     (clock),
        .arst_n    (arst_n),
        .flush     (redirect_valid),
        .head_valid(head_valid),
        .head_entry(head_entry),
        .head_ready(head_ready),
        .dec_valid (dec_valid),
        .dec_inst  (dec_inst),
        .dec_ready (dec_ready)
    );

    regfile u_regfile (
        .clock   (clock),
        .arst_n  (arst_n),
        .rs1     (rs1),
        .rs2     (rs2),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .wb      (wb)
    );

    operand_stage u_operand_stage (
        .dec_valid  (dec_valid),
        .dec_inst   (dec_inst),
        .dec_ready  (dec_ready),
        .ex_byp     (ex_byp),
        .mem_byp    (mem_byp),
        .rs1        (rs1),
        .rs2        (rs2),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .issue_valid(issue_valid),
        .issue_inst (issue_inst),
        .src1       (src1),
        .src2       (src2),
        .issue_ready(issue_ready)
    );

endmodule

`default_nettype wire

// ==== verilog/inst_buffer.sv ====
`default_nettype none

module inst_buffer import fe_pkg::*; #(
    parameter int DEPTH = 8
) (
    input  wire         clock,
    input  wire         arst_n,
    input  wire         flush,

    input  wire         push_valid,
    input  ibuf_entry_t push_entry,
    output logic        push_ready,

    output logic        head_valid,
    output ibuf_entry_t head_entry,
    input  wire         head_ready
);

    localparam int PTR_W = $clog2(DEPTH);

    ibuf_entry_t        mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;
    logic               do_push;
    logic               do_pop;

    assign push_ready = (count != (PTR_W+1)'(DEPTH));
    assign head_valid = (count != '0);
    assign head_entry = mem[rd_ptr];

    assign do_push = push_valid && push_ready;
    assign do_pop  = head_valid && head_ready;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            count <= count + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
        end
    end

    always_ff @(posedge clock) begin
        if (do_push) mem[wr_ptr] <= push_entry;
    end

endmodule

`default_nettype wire

// ==== verilog/operand_stage.sv ====
`default_nettype none

module operand_stage import fe_pkg::*; (
    input  wire      dec_valid,
    input  decoded_t dec_inst,
    output logic     dec_ready,

    input  bypass_t  ex_byp,
    input  bypass_t  mem_byp,

    output lreg_t    rs1,
    output lreg_t    rs2,
    input  xreg_t    rs1_data,
    input  xreg_t    rs2_data,

    output logic     issue_valid,
    output decoded_t issue_inst,
    output xreg_t    src1,
    output xreg_t    src2,
    input  wire      issue_ready
);

    xreg_t rs1_fwd;
    xreg_t rs2_fwd;

    // ex wins over mem, x0 never forwarded
    function automatic xreg_t forward(lreg_t r, xreg_t rf_data, bypass_t ex, bypass_t mem);
        xreg_t value;
        value = rf_data;
        if (r != '0) begin
            if (ex.valid && ex.rd == r) begin
                value = ex.result;
            end else if (mem.valid && mem.rd == r) begin
                value = mem.result;
            end
        end
        return value;
    endfunction

    assign rs1 = dec_inst.rs1;
    assign rs2 = dec_inst.rs2;

    assign rs1_fwd = forward(dec_inst.rs1, rs1_data, ex_byp, mem_byp);
    assign rs2_fwd = forward(dec_inst.rs2, rs2_data, ex_byp, mem_byp);

    always_comb begin
        if (dec_inst.src1_is_reg) begin
            src1 = rs1_fwd;
        end else if (dec_inst.inst[6:0] == OPC_AUIPC) begin
            src1 = {{(XLEN-48){1'b0}}, dec_inst.pc};
        end else begin
            src1 = '0; // lui and illegal
        end
    end

    assign src2 = dec_inst.src2_is_reg ? rs2_fwd : dec_inst.imm;

    assign issue_valid = dec_valid;
    assign issue_inst  = dec_inst;
    assign dec_ready   = issue_ready;

endmodule

`default_nettype wire

// ==== verilog/regfile.sv ====
`default_nettype none

module regfile import fe_pkg::*; (
    input  wire     clock,
    input  wire     arst_n,

    input  lreg_t   rs1,
    input  lreg_t   rs2,
    output xreg_t   rs1_data,
    output xreg_t   rs2_data,

    input  bypass_t wb
);

    xreg_t regs [1:31]; // no storage for x0

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.result;
        end
    end

    // same-cycle write is not visible here
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire
